/* CorePkg.sv */
`default_nettype none

package CorePkg;

    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_BITS = 5;
    localparam int ROB_SIZE = 8;
    localparam int SQN_BITS = 4; // one bit more than the entry index
    localparam int DIV_CYCLES = 32;

    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } AluOp;

    // the same 32 bits seen as an R-type or an I-type instruction
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
    } InstrWord;

endpackage

`default_nettype wire

/* InstrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module InstrDecoder import CorePkg::*; (
    input wire InstrWord instr,
    output logic isDiv,
    output logic isRem,
    output logic useImm,
    output logic legal,
    output AluOp aluOp,
    output logic [REG_BITS-1:0] rs1,
    output logic [REG_BITS-1:0] rs2,
    output logic [REG_BITS-1:0] rd,
    output logic [XLEN-1:0] imm
);

    always_comb begin
        isDiv = 1'b0;
        isRem = 1'b0;
        useImm = 1'b0;
        legal = 1'b0;
        aluOp = ALU_ADD; // anything unknown becomes ADD into x0
        rs1 = instr.r.rs1;
        rs2 = instr.r.rs2;
        rd = '0;
        imm = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

        if (instr.r.opcode == OPC_OP) begin
            if (instr.r.funct7 == FUNCT7_MULDIV) begin
                isDiv = (instr.r.funct3 == 3'b101) || (instr.r.funct3 == 3'b111);
                isRem = instr.r.funct3 == 3'b111;
                legal = isDiv;
            end else if (instr.r.funct7 == FUNCT7_SUB) begin
                legal = instr.r.funct3 == 3'b000;
                aluOp = ALU_SUB;
            end else if (instr.r.funct7 == 7'b0000000) begin
                legal = 1'b1;
                case (instr.r.funct3)
                    3'b000: aluOp = ALU_ADD;
                    3'b010: aluOp = ALU_SLT;
                    3'b100: aluOp = ALU_XOR;
                    3'b110: aluOp = ALU_OR;
                    3'b111: aluOp = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
        end else if (instr.i.opcode == OPC_OPIMM && instr.i.funct3 == 3'b000) begin
            legal = 1'b1; // ADDI
            useImm = 1'b1;
        end

        if (!legal) begin
            aluOp = ALU_ADD;
        end else begin
            rd = instr.r.rd;
        end
    end

endmodule

`default_nettype wire

/* RF.sv */
`timescale 1ns/10ps
`default_nettype none

module RF import CorePkg::*; (
    input wire clk,
    input wire [REG_BITS-1:0] raddrA,
    input wire [REG_BITS-1:0] raddrB,
    output logic [XLEN-1:0] rdataA,
    output logic [XLEN-1:0] rdataB,
    input wire we,
    input wire [REG_BITS-1:0] waddr,
    input wire [XLEN-1:0] wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired, its array slot is never written
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

/* IntALU.sv */
`timescale 1ns/10ps
`default_nettype none

module IntALU import CorePkg::*; (
    input wire clk,
    input wire rst,
    input wire start,
    input wire AluOp op,
    input wire [SQN_BITS-1:0] sqN,
    input wire [XLEN-1:0] opA,
    input wire [XLEN-1:0] opB,
    output logic wbValid,
    output logic [SQN_BITS-1:0] wbSqN,
    output logic [XLEN-1:0] wbData
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (op)
            ALU_SUB: result = opA - opB;
            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_XOR: result = opA ^ opB;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: result = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wbSqN <= sqN;
            wbData <= result;
        end
    end

endmodule

`default_nettype wire

/* Divide.sv */
`timescale 1ns/10ps
`default_nettype none

module Divide import CorePkg::*; (
    input wire clk,
    input wire rst,
    input wire start,
    input wire wantRem,
    input wire [SQN_BITS-1:0] sqN,
    input wire [XLEN-1:0] dividend,
    input wire [XLEN-1:0] divisor,
    output logic busy,
    output logic wbValid,
    output logic [SQN_BITS-1:0] wbSqN,
    output logic [XLEN-1:0] wbData
);

    logic [$clog2(DIV_CYCLES+1)-1:0] cnt;
    logic [XLEN-1:0] quo; // holds the dividend bits not yet shifted out
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dvs;
    logic remSel;
    logic [XLEN:0] shifted;
    logic [XLEN:0] diff;

    assign shifted = {rem, quo[XLEN-1]};
    assign diff = shifted - {1'b0, dvs};

    // a zero divisor never goes negative, which yields all ones and the dividend
    assign wbValid = busy && (cnt == DIV_CYCLES[$bits(cnt)-1:0]);
    assign wbData = remSel ? rem : quo;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt <= '0;
        end else if (wbValid) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo <= dividend;
            rem <= '0;
            dvs <= divisor;
            remSel <= wantRem;
            wbSqN <= sqN;
        end else if (busy && !wbValid) begin
            if (diff[XLEN]) begin
                rem <= shifted[XLEN-1:0]; // restore
                quo <= {quo[XLEN-2:0], 1'b0};
            end else begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

/* ROB.sv */
`timescale 1ns/10ps
`default_nettype none

module ROB import CorePkg::*; (
    input wire clk,
    input wire rst,
    input wire dispValid,
    input wire [SQN_BITS-1:0] dispSqN,
    input wire [REG_BITS-1:0] dispReg,
    input wire aluWbValid,
    input wire [SQN_BITS-1:0] aluWbSqN,
    input wire [XLEN-1:0] aluWbData,
    input wire divWbValid,
    input wire [SQN_BITS-1:0] divWbSqN,
    input wire [XLEN-1:0] divWbData,
    output logic robFull,
    output logic commitValid,
    output logic [REG_BITS-1:0] commitReg,
    output logic [XLEN-1:0] commitData
);

    logic [SQN_BITS-1:0] head;
    logic [SQN_BITS-1:0] tail;
    logic [ROB_SIZE-1:0] done;
    logic [REG_BITS-1:0] dest [ROB_SIZE];
    logic [XLEN-1:0] result [ROB_SIZE];
    logic [SQN_BITS-2:0] headIdx;

    assign headIdx = head[SQN_BITS-2:0];

    // pointers carry one wrap bit, equal index with different wrap means full
    assign robFull = (tail[SQN_BITS-1] != head[SQN_BITS-1])
        && (tail[SQN_BITS-2:0] == headIdx);

    assign commitValid = done[headIdx];
    assign commitReg = dest[headIdx];
    assign commitData = (commitReg == '0) ? '0 : result[headIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            done <= '0;
        end else begin
            if (dispValid) begin
                tail <= tail + 1'b1;
                done[dispSqN[SQN_BITS-2:0]] <= 1'b0;
            end
            if (aluWbValid) begin
                done[aluWbSqN[SQN_BITS-2:0]] <= 1'b1;
            end
            if (divWbValid) begin
                done[divWbSqN[SQN_BITS-2:0]] <= 1'b1;
            end
            if (commitValid) begin
                done[headIdx] <= 1'b0; // slot is free again once retired
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispValid) begin
            dest[dispSqN[SQN_BITS-2:0]] <= dispReg;
        end
        if (aluWbValid) begin
            result[aluWbSqN[SQN_BITS-2:0]] <= aluWbData;
        end
        if (divWbValid) begin
            result[divWbSqN[SQN_BITS-2:0]] <= divWbData;
        end
    end

endmodule

`default_nettype wire

/* Issue.sv */
`timescale 1ns/10ps
`default_nettype none

module Issue import CorePkg::*; (
    input wire clk,
    input wire rst,
    input wire instrValid,
    input wire [XLEN-1:0] instr,
    output logic stall,
    input wire robFull,
    input wire divBusy,
    input wire commitValid,
    input wire [REG_BITS-1:0] commitReg,
    output logic [REG_BITS-1:0] rfAddrA,
    output logic [REG_BITS-1:0] rfAddrB,
    input wire [XLEN-1:0] rfDataA,
    input wire [XLEN-1:0] rfDataB,
    output logic aluStart,
    output logic divStart,
    output logic wantRem,
    output AluOp aluOp,
    output logic [XLEN-1:0] opA,
    output logic [XLEN-1:0] opB,
    output logic [SQN_BITS-1:0] sqN,
    output logic dispValid,
    output logic [REG_BITS-1:0] dispReg
);

    logic heldValid;
    logic [XLEN-1:0] heldInstr;
    logic [NUM_REGS-1:0] pending;
    logic isDiv;
    logic useImm;
    logic legal;
    logic [XLEN-1:0] imm;
    logic hazard;
    logic canDispatch;

    InstrDecoder decoder (
        .instr(heldInstr),
        .isDiv(isDiv),
        .isRem(wantRem),
        .useImm(useImm),
        .legal(legal),
        .aluOp(aluOp),
        .rs1(rfAddrA),
        .rs2(rfAddrB),
        .rd(dispReg),
        .imm(imm)
    );

    // the destination check keeps at most one writer per register in flight
    assign hazard = legal && (pending[rfAddrA] || (!useImm && pending[rfAddrB])
        || pending[dispReg]);
    assign canDispatch = !hazard && !(isDiv && divBusy) && !robFull;

    assign dispValid = heldValid && canDispatch;
    assign stall = heldValid && !canDispatch;
    assign aluStart = dispValid && !isDiv;
    assign divStart = dispValid && isDiv;
    assign opA = rfDataA;
    assign opB = useImm ? imm : rfDataB;

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
            pending <= '0;
            sqN <= '0;
        end else begin
            if (instrValid && !stall) begin
                heldValid <= 1'b1;
            end else if (dispValid) begin
                heldValid <= 1'b0;
            end
            if (commitValid) begin
                pending[commitReg] <= 1'b0;
            end
            if (dispValid && dispReg != '0) begin
                pending[dispReg] <= 1'b1;
            end
            if (dispValid) begin
                sqN <= sqN + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && !stall) begin
            heldInstr <= instr;
        end
    end

endmodule

`default_nettype wire

/* Core.sv */
`timescale 1ns/10ps
`default_nettype none

module Core import CorePkg::*; (
    input wire clk,
    input wire rst,
    input wire instrValid,
    input wire [XLEN-1:0] instr,
    output logic stall,
    output logic commitValid,
    output logic [REG_BITS-1:0] commitReg,
    output logic [XLEN-1:0] commitData
);

    wire robFull;
    wire divBusy;
    wire [REG_BITS-1:0] rfAddrA;
    wire [REG_BITS-1:0] rfAddrB;
    wire [XLEN-1:0] rfDataA;
    wire [XLEN-1:0] rfDataB;
    wire aluStart;
    wire divStart;
    wire wantRem;
    AluOp aluOp;
    wire [XLEN-1:0] opA;
    wire [XLEN-1:0] opB;
    wire [SQN_BITS-1:0] sqN;
    wire dispValid;
    wire [REG_BITS-1:0] dispReg;
    wire aluWbValid;
    wire [SQN_BITS-1:0] aluWbSqN;
    wire [XLEN-1:0] aluWbData;
    wire divWbValid;
    wire [SQN_BITS-1:0] divWbSqN;
    wire [XLEN-1:0] divWbData;

    Issue issue (
        .clk(clk), .rst(rst),
        .instrValid(instrValid), .instr(instr), .stall(stall),
        .robFull(robFull), .divBusy(divBusy),
        .commitValid(commitValid), .commitReg(commitReg),
        .rfAddrA(rfAddrA), .rfAddrB(rfAddrB), .rfDataA(rfDataA), .rfDataB(rfDataB),
        .aluStart(aluStart), .divStart(divStart), .wantRem(wantRem), .aluOp(aluOp),
        .opA(opA), .opB(opB), .sqN(sqN), .dispValid(dispValid), .dispReg(dispReg)
    );

    RF rf (
        .clk(clk),
        .raddrA(rfAddrA), .raddrB(rfAddrB), .rdataA(rfDataA), .rdataB(rfDataB),
        .we(commitValid), .waddr(commitReg), .wdata(commitData)
    );

    IntALU alu (
        .clk(clk), .rst(rst),
        .start(aluStart), .op(aluOp), .sqN(sqN), .opA(opA), .opB(opB),
        .wbValid(aluWbValid), .wbSqN(aluWbSqN), .wbData(aluWbData)
    );

    Divide div (
        .clk(clk), .rst(rst),
        .start(divStart), .wantRem(wantRem), .sqN(sqN), .dividend(opA), .divisor(opB),
        .busy(divBusy), .wbValid(divWbValid), .wbSqN(divWbSqN), .wbData(divWbData)
    );

    ROB rob (
        .clk(clk), .rst(rst),
        .dispValid(dispValid), .dispSqN(sqN), .dispReg(dispReg),
        .aluWbValid(aluWbValid), .aluWbSqN(aluWbSqN), .aluWbData(aluWbData),
        .divWbValid(divWbValid), .divWbSqN(divWbSqN), .divWbData(divWbData),
        .robFull(robFull),
        .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
    );

endmodule

`default_nettype wire

/* Core_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module CoreProperties import CorePkg::*; (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire commitValid,
    input wire [REG_BITS-1:0] commitReg,
    input wire [XLEN-1:0] commitData,
    input wire divBusy,
    input wire divStart
);

    resetIdle: assert property (@(posedge clk) rst |=> !commitValid && !stall && !divBusy)
        else $error("commitValid, stall or divider busy high after a reset cycle");

    // x0 is hardwired, so its commits carry zero
    zeroCommit: assert property (@(posedge clk) disable iff (rst)
        commitValid && commitReg == '0 |-> commitData == '0)
        else $error("commit to x0 with nonzero data %h", commitData);

    divOverlap: assert property (@(posedge clk) disable iff (rst) divStart |-> !divBusy)
        else $error("divide started while the divider was busy");

endmodule

bind Core CoreProperties coreProps (
    .clk(clk), .rst(rst), .stall(stall),
    .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
    .divBusy(divBusy), .divStart(divStart)
);

`default_nettype wire

/* tb_Core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_Core import CorePkg::*; ();

    // about 260 instructions and up to 60 divides of 34 cycles fit with wide margin
    localparam int CYCLE_LIMIT = 20000;

    logic clk = 1'b0;
    logic rst;
    logic instrValid;
    logic [XLEN-1:0] instr;
    logic stall;
    logic commitValid;
    logic [REG_BITS-1:0] commitReg;
    logic [XLEN-1:0] commitData;

    logic [REG_BITS+XLEN-1:0] expQ [$]; // {rd, data} per instruction, in program order
    logic [XLEN-1:0] refRegs [NUM_REGS];
    int errors = 0;
    int checks = 0;
    int testNum = 1;
    int checksAtStart = 0;
    int errorsAtStart = 0;
    int cycles = 0;

    Core Core_inst (
        .clk(clk), .rst(rst),
        .instrValid(instrValid), .instr(instr), .stall(stall),
        .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
    );

    always #4 clk = ~clk;

    // executes one word on the architectural state in program order
    function automatic logic [REG_BITS+XLEN-1:0] refExecute(input InstrWord w);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [REG_BITS-1:0] rd;
        logic ok;
        a = refRegs[w.r.rs1];
        b = refRegs[w.r.rs2];
        res = '0;
        rd = w.r.rd;
        ok = 1'b1;
        if (w.r.opcode == OPC_OP && w.r.funct7 == 7'b0000000) begin
            case (w.r.funct3)
                3'b000: res = a + b;
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b110: res = a | b;
                3'b111: res = a & b;
                default: ok = 1'b0;
            endcase
        end else if (w.r.opcode == OPC_OP && w.r.funct7 == FUNCT7_SUB
                && w.r.funct3 == 3'b000) begin
            res = a - b;
        end else if (w.r.opcode == OPC_OP && w.r.funct7 == FUNCT7_MULDIV
                && w.r.funct3 == 3'b101) begin
            res = (b == 0) ? 32'hffff_ffff : a / b;
        end else if (w.r.opcode == OPC_OP && w.r.funct7 == FUNCT7_MULDIV
                && w.r.funct3 == 3'b111) begin
            res = (b == 0) ? a : a % b;
        end else if (w.i.opcode == OPC_OPIMM && w.i.funct3 == 3'b000) begin
            res = a + {{20{w.i.imm12[11]}}, w.i.imm12};
        end else begin
            ok = 1'b0;
        end
        if (!ok || rd == '0) begin
            rd = '0; // unsupported words and x0 targets retire as zero into x0
            res = '0;
        end else begin
            refRegs[rd] = res;
        end
        return {rd, res};
    endfunction

    function automatic logic [XLEN-1:0] rType(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        InstrWord w;
        w.r.funct7 = f7;
        w.r.rs2 = rs2;
        w.r.rs1 = rs1;
        w.r.funct3 = f3;
        w.r.rd = rd;
        w.r.opcode = OPC_OP;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] addiWord(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [4:0] rd);
        InstrWord w;
        w.i.imm12 = imm;
        w.i.rs1 = rs1;
        w.i.funct3 = 3'b000;
        w.i.rd = rd;
        w.i.opcode = OPC_OPIMM;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] divWord(input logic rem, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        return rType(FUNCT7_MULDIV, rem ? 3'b111 : 3'b101, rd, rs1, rs2);
    endfunction

    function automatic logic [XLEN-1:0] randomAlu(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2);
        case ($urandom_range(0, 5))
            0: return rType(7'b0000000, 3'b000, rd, rs1, rs2);
            1: return rType(FUNCT7_SUB, 3'b000, rd, rs1, rs2);
            2: return rType(7'b0000000, 3'b010, rd, rs1, rs2);
            3: return rType(7'b0000000, 3'b100, rd, rs1, rs2);
            4: return rType(7'b0000000, 3'b110, rd, rs1, rs2);
            default: return rType(7'b0000000, 3'b111, rd, rs1, rs2);
        endcase
    endfunction

    // entered on a falling edge and holds the word until a cycle without stall
    task automatic sendInstr(input logic [XLEN-1:0] word);
        logic accepted;
        accepted = 1'b0;
        instrValid = 1'b1;
        instr = word;
        expQ.push_back(refExecute(word));
        while (!accepted) begin
            accepted = !stall; // stall only moves on rising edges
            @(negedge clk);
        end
        instrValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // room for a stray extra commit to show up
    endtask

    task automatic finishTest(input string name);
        $display("test %0d %s: %0d checks, %0d errors", testNum, name,
            checks - checksAtStart, errors - errorsAtStart);
        testNum++;
        checksAtStart = checks;
        errorsAtStart = errors;
    endtask

    always @(negedge clk) begin
        logic [REG_BITS+XLEN-1:0] expected;
        if (!rst && commitValid) begin
            checks++;
            assert (expQ.size() != 0) else begin
                errors++;
                $display("commit to x%0d arrived with no instruction outstanding", commitReg);
            end
            if (expQ.size() != 0) begin
                expected = expQ.pop_front();
                assert (commitReg == expected[XLEN+REG_BITS-1:XLEN]) else begin
                    errors++;
                    $display("mismatch commitReg: got %h expected %h", commitReg,
                        expected[XLEN+REG_BITS-1:XLEN]);
                end
                assert (commitData == expected[XLEN-1:0]) else begin
                    errors++;
                    $display("mismatch commitData: got %h expected %h", commitData,
                        expected[XLEN-1:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int kind;
        logic [4:0] rd;
        void'($urandom(74));
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        foreach (refRegs[i]) refRegs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checks++;
        assert (!stall) else begin
            errors++;
            $display("mismatch stall: got %h expected %h", stall, 1'b0);
        end
        checks++;
        assert (!commitValid) else begin
            errors++;
            $display("mismatch commitValid: got %h expected %h", commitValid, 1'b0);
        end
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (!stall) else begin
                errors++;
                $display("mismatch stall: got %h expected %h", stall, 1'b0);
            end
        end
        finishTest("idle after reset");

        for (int r = 1; r < NUM_REGS; r++) begin
            sendInstr(addiWord(12'($urandom), 5'd0, 5'(r))); // defined state for every register
        end
        repeat (40) begin
            sendInstr(randomAlu(5'($urandom_range(1, 31)), 5'($urandom), 5'($urandom)));
        end
        waitDrain();
        finishTest("random ALU");

        repeat (8) begin
            sendInstr(addiWord({1'b1, 11'($urandom)}, 5'($urandom), 5'($urandom_range(1, 31))));
        end
        sendInstr(addiWord(12'h07b, 5'd5, 5'd0));
        sendInstr(rType(7'b0000000, 3'b000, 5'd0, 5'd3, 5'd4));
        sendInstr(rType(7'b0000000, 3'b000, 5'd7, 5'd0, 5'd0));
        sendInstr(addiWord(12'hfff, 5'd0, 5'd8));
        sendInstr(rType(7'b0000000, 3'b110, 5'd9, 5'd0, 5'd0));
        waitDrain();
        finishTest("ADDI and x0");

        sendInstr(addiWord(12'd3, 5'd0, 5'd10));
        sendInstr(addiWord(12'hff9, 5'd0, 5'd11));
        sendInstr(divWord(1'b0, 5'd12, 5'd5, 5'd10));
        sendInstr(divWord(1'b1, 5'd13, 5'd5, 5'd10));
        sendInstr(divWord(1'b0, 5'd14, 5'd5, 5'd0));
        sendInstr(divWord(1'b1, 5'd15, 5'd5, 5'd0));
        sendInstr(divWord(1'b0, 5'd16, 5'd10, 5'd11));
        repeat (10) begin
            sendInstr(divWord(1'($urandom), 5'($urandom_range(17, 31)), 5'($urandom),
                5'($urandom_range(1, 31))));
        end
        waitDrain();
        finishTest("DIVU and REMU");

        sendInstr(divWord(1'b0, 5'd20, 5'd1, 5'd10));
        for (int r = 21; r < 27; r++) begin
            sendInstr(randomAlu(5'(r), 5'($urandom_range(2, 8)), 5'($urandom_range(2, 8))));
        end
        waitDrain();
        finishTest("ALU behind divide");

        for (int n = 0; n < 150; n++) begin
            kind = $urandom_range(0, 9);
            rd = 5'($urandom_range(1, 6)); // few registers so chains and hazards form
            case (kind)
                0, 1, 2, 3: sendInstr(randomAlu(rd, 5'($urandom_range(0, 6)),
                    5'($urandom_range(0, 6))));
                4, 5, 6: sendInstr(addiWord(12'($urandom), 5'($urandom_range(0, 6)), rd));
                7: sendInstr(divWord(1'($urandom), rd, 5'($urandom_range(0, 6)),
                    5'($urandom_range(0, 6))));
                8: sendInstr($urandom);
                default: begin
                    sendInstr(randomAlu(rd, rd, 5'($urandom_range(0, 6))));
                    repeat (2) @(negedge clk);
                end
            endcase
        end
        waitDrain();
        finishTest("random mix");

        $display("tests: %0d, checks: %0d, errors: %0d", testNum - 1, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
CorePkg.sv
InstrDecoder.sv
RF.sv
IntALU.sv
Divide.sv
ROB.sv
Issue.sv
Core.sv
Core_properties.sv
tb_Core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_Core -f src.f -o simCore
./obj_dir/simCore > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
